/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_rv_exec_top
FILELIST  = all.f
OBJ_DIR   = obj_dir

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "Simulation passed" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

.PHONY: sim clean

/* all.f */
rv_exec_pkg.sv
decode_if.sv
instr_queue.sv
credit_counter.sv
reg_file.sv
id_stage.sv
id_ex.sv
ex_stage.sv
rv_exec_top.sv
tb_rv_exec_top.sv

/* credit_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module credit_counter #(
    parameter int OUT_CREDITS = 4
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic spend_i,
    input  logic return_i,
    output logic avail_o
);

    localparam int CNT_W = $clog2(OUT_CREDITS + 1);
    localparam logic [CNT_W-1:0] MAX_CNT = CNT_W'(OUT_CREDITS);

    logic [CNT_W-1:0] count;

    assign avail_o = (count != '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count <= MAX_CNT;
        end else begin
            case ({spend_i, return_i})
                2'b10: count <= count - 1'b1;
                // saturate so a stray return cannot inflate the pool
                2'b01: count <= (count == MAX_CNT) ? count : count + 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* decode_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface decode_if import rv_exec_pkg::*; ();

    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    data_t     imm;
    alu_op_e   alu_op;
    logic      use_imm;
    // we is already low for bubbles, x0 and unsupported opcodes
    logic      we;
    logic      valid;

    modport decode (
        output rs1, rs2, rd, imm, alu_op, use_imm, we, valid
    );

    modport register (
        input rs1, rs2, rd, imm, alu_op, use_imm, we, valid
    );

endinterface

`default_nettype wire

/* ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage import rv_exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      valid_i,
    input  logic      we_i,
    input  reg_addr_t rd_i,
    input  alu_op_e   alu_op_i,
    input  data_t     op_a_i,
    input  data_t     op_b_i,
    output data_t     result_o,
    output logic      wb_valid_o,
    output logic      wb_we_o,
    output reg_addr_t wb_rd_o,
    output data_t     wb_data_o
);

    logic [4:0] shamt;

    assign shamt = op_b_i[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    result_o = op_a_i + op_b_i;
            ALU_SUB:    result_o = op_a_i - op_b_i;
            ALU_SLL:    result_o = op_a_i << shamt;
            ALU_SLT:    result_o = data_t'($signed(op_a_i) < $signed(op_b_i));
            ALU_SLTU:   result_o = data_t'(op_a_i < op_b_i);
            ALU_XOR:    result_o = op_a_i ^ op_b_i;
            ALU_SRL:    result_o = op_a_i >> shamt;
            ALU_SRA:    result_o = data_t'($signed(op_a_i) >>> shamt);
            ALU_OR:     result_o = op_a_i | op_b_i;
            ALU_AND:    result_o = op_a_i & op_b_i;
            ALU_PASS_B: result_o = op_b_i;
            default:    result_o = '0;
        endcase
    end

    // ex/wb register, also the result port
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
        end else begin
            wb_valid_o <= valid_i;
            wb_we_o    <= valid_i && we_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o   <= rd_i;
        wb_data_o <= result_o;
    end

endmodule

`default_nettype wire

/* id_ex.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex import rv_exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    decode_if.register dec,
    input  data_t     rdata1_i,
    input  data_t     rdata2_i,
    input  logic      ex_valid_i,
    input  logic      ex_we_i,
    input  reg_addr_t ex_rd_i,
    input  data_t     ex_result_i,
    input  logic      wb_valid_i,
    input  logic      wb_we_i,
    input  reg_addr_t wb_rd_i,
    input  data_t     wb_data_i,
    output logic      valid_o,
    output logic      we_o,
    output reg_addr_t rd_o,
    output alu_op_e   alu_op_o,
    output data_t     op_a_o,
    output data_t     op_b_o
);

    data_t op_a_d;
    data_t op_b_d;

    // ex holds the younger of the two producers, so it is checked last and wins
    function automatic data_t bypass(input reg_addr_t rs, input data_t rf_data);
        data_t sel;
        sel = rf_data;
        if ((rs != '0) && wb_valid_i && wb_we_i && (wb_rd_i == rs)) begin
            sel = wb_data_i;
        end
        if ((rs != '0) && ex_valid_i && ex_we_i && (ex_rd_i == rs)) begin
            sel = ex_result_i;
        end
        return sel;
    endfunction

    always_comb begin
        op_a_d = bypass(dec.rs1, rdata1_i);
        op_b_d = dec.use_imm ? dec.imm : bypass(dec.rs2, rdata2_i);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            we_o    <= 1'b0;
        end else begin
            valid_o <= dec.valid;
            we_o    <= dec.we;
        end
    end

    always_ff @(posedge clk) begin
        rd_o     <= dec.rd;
        alu_op_o <= dec.alu_op;
        op_a_o   <= op_a_d;
        op_b_o   <= op_b_d;
    end

endmodule

`default_nettype wire

/* id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage import rv_exec_pkg::*; (
    input  logic   valid_i,
    input  instr_t instr_i,
    decode_if.decode dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       supported;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign dec.rs1   = instr_i[19:15];
    assign dec.rs2   = instr_i[24:20];
    assign dec.rd    = instr_i[11:7];
    assign dec.valid = valid_i;

    assign supported = (opcode == OPC_OP) || (opcode == OPC_OP_IMM) || (opcode == OPC_LUI);
    assign dec.we    = valid_i && supported && (instr_i[11:7] != '0);

    always_comb begin
        dec.use_imm = (opcode != OPC_OP);
        // i-type sign extended, u-type upper twenty bits
        if (opcode == OPC_LUI) begin
            dec.imm = {instr_i[31:12], 12'b0};
        end else begin
            dec.imm = {{20{instr_i[31]}}, instr_i[31:20]};
        end

        case (funct3)
            3'b000: begin
                // sub only exists in the register form
                if ((opcode == OPC_OP) && funct7[5]) begin
                    dec.alu_op = ALU_SUB;
                end else begin
                    dec.alu_op = ALU_ADD;
                end
            end
            3'b001: dec.alu_op = ALU_SLL;
            3'b010: dec.alu_op = ALU_SLT;
            3'b011: dec.alu_op = ALU_SLTU;
            3'b100: dec.alu_op = ALU_XOR;
            3'b101: dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110: dec.alu_op = ALU_OR;
            default: dec.alu_op = ALU_AND;
        endcase

        if (opcode == OPC_LUI) begin
            dec.alu_op = ALU_PASS_B;
        end
    end

endmodule

`default_nettype wire

/* instr_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_queue import rv_exec_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   push_i,
    input  instr_t push_data_i,
    input  logic   pop_i,
    output logic   empty_o,
    output instr_t head_o,
    output logic   credit_o
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(QUEUE_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(QUEUE_DEPTH);

    instr_t            mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    assign empty_o = (count == '0);
    assign head_o  = mem[rd_ptr];

    // sender holds a credit for every push, so a full queue only drops on misuse
    assign do_push = push_i && (count != FULL_CNT);
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            count    <= count + CNT_W'(do_push) - CNT_W'(do_pop);
            // one credit back per popped slot, a cycle late
            credit_o <= do_pop;
        end
    end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output data_t     rdata1_o,
    output data_t     rdata2_o,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  data_t     wdata_i
);

    data_t regs [32];

    // x0 reads as zero whatever the array holds
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

/* rv_exec_pkg.sv */
`default_nettype none

package rv_exec_pkg;

    // register value and register index
    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_addr_t;

    // raw instruction word
    typedef logic [31:0] instr_t;

    // alu operations, pass_b carries the lui immediate straight through
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // supported major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

endpackage

`default_nettype wire

/* rv_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top import rv_exec_pkg::*; #(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 4
) (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      instr_valid_i,
    input  instr_t    instr_i,
    output logic      credit_o,
    input  logic      res_credit_i,
    output logic      res_valid_o,
    output logic      res_we_o,
    output reg_addr_t res_rd_o,
    output data_t     res_data_o
);

    logic      q_empty;
    instr_t    q_head;
    logic      cr_avail;
    logic      issue;
    data_t     rdata1;
    data_t     rdata2;
    logic      ex_valid;
    logic      ex_we;
    reg_addr_t ex_rd;
    alu_op_e   ex_alu_op;
    data_t     ex_op_a;
    data_t     ex_op_b;
    data_t     ex_result;

    decode_if dec_if ();

    // issue needs an instruction and a free result slot, nothing else can stall
    assign issue = !q_empty && cr_avail;

    instr_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) instr_queue_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .push_i(instr_valid_i), .push_data_i(instr_i),
        .pop_i(issue), .empty_o(q_empty), .head_o(q_head), .credit_o(credit_o)
    );

    credit_counter #(.OUT_CREDITS(OUT_CREDITS)) credit_counter_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .spend_i(issue), .return_i(res_credit_i), .avail_o(cr_avail)
    );

    id_stage id_stage_inst (.valid_i(issue), .instr_i(q_head), .dec(dec_if.decode));

    reg_file reg_file_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .raddr1_i(dec_if.rs1), .raddr2_i(dec_if.rs2),
        .rdata1_o(rdata1), .rdata2_o(rdata2),
        .we_i(res_valid_o && res_we_o), .waddr_i(res_rd_o), .wdata_i(res_data_o)
    );

    id_ex id_ex_inst (
        .clk(clk), .rst_n_i(rst_n_i), .dec(dec_if.register),
        .rdata1_i(rdata1), .rdata2_i(rdata2),
        .ex_valid_i(ex_valid), .ex_we_i(ex_we), .ex_rd_i(ex_rd), .ex_result_i(ex_result),
        .wb_valid_i(res_valid_o), .wb_we_i(res_we_o), .wb_rd_i(res_rd_o),
        .wb_data_i(res_data_o),
        .valid_o(ex_valid), .we_o(ex_we), .rd_o(ex_rd), .alu_op_o(ex_alu_op),
        .op_a_o(ex_op_a), .op_b_o(ex_op_b)
    );

    ex_stage ex_stage_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .valid_i(ex_valid), .we_i(ex_we), .rd_i(ex_rd), .alu_op_i(ex_alu_op),
        .op_a_i(ex_op_a), .op_b_i(ex_op_b), .result_o(ex_result),
        .wb_valid_o(res_valid_o), .wb_we_o(res_we_o), .wb_rd_o(res_rd_o),
        .wb_data_o(res_data_o)
    );

endmodule

`default_nettype wire

/* tb_rv_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec_top import rv_exec_pkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int QUEUE_DEPTH  = 4;
    localparam int OUT_CREDITS  = 4;
    localparam int NUM_RANDOM   = 200;
    localparam int MAX_INSTR    = 256;

    logic      clk;
    logic      rst_n_i;
    logic      instr_valid_i;
    instr_t    instr_i;
    logic      credit_o;
    logic      res_credit_i;
    logic      res_valid_o;
    logic      res_we_o;
    reg_addr_t res_rd_o;
    data_t     res_data_o;

    // program and the beats predicted for it
    instr_t    prog [MAX_INSTR];
    reg_addr_t exp_rd_mem [MAX_INSTR];
    logic      exp_we_mem [MAX_INSTR];
    data_t     exp_data_mem [MAX_INSTR];
    logic      exp_chk_mem [MAX_INSTR];
    data_t     ref_regs [32];
    int        num_instr;

    integer    seed;
    bit        run;
    bit        withhold;
    bit        sent_any;
    int        sent;
    int        in_credits;
    int        credit_pulses;
    int        beats_in;
    int        credits_out;
    int        rx_wait;
    int        beat_held;
    reg_addr_t exp_rd;
    logic      exp_we;
    data_t     exp_data;
    logic      exp_chk;

    rv_exec_top rv_exec_top_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .instr_valid_i(instr_valid_i), .instr_i(instr_i), .credit_o(credit_o),
        .res_credit_i(res_credit_i), .res_valid_o(res_valid_o), .res_we_o(res_we_o),
        .res_rd_o(res_rd_o), .res_data_o(res_data_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_value(input string what, input data_t got, input data_t expected);
        $display("error: time %0t: %s, got %h, expected %h", $time, what, got, expected);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_plain(input string what);
        $display("%s at time %0t", what, $time);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic instr_t r_type_word(input logic [6:0] f7, input reg_addr_t rs2,
                                           input reg_addr_t rs1, input logic [2:0] f3,
                                           input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t i_type_word(input logic [11:0] imm, input reg_addr_t rs1,
                                           input logic [2:0] f3, input reg_addr_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic instr_t lui_word(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // in-order ISA model that runs one instruction at a time
    task automatic predict_beat(input int idx);
        instr_t     w;
        logic [6:0] opc;
        logic [2:0] f3;
        data_t      a;
        data_t      b;
        data_t      r;
        logic       known;
        w     = prog[idx];
        opc   = w[6:0];
        f3    = w[14:12];
        a     = ref_regs[w[19:15]];
        b     = (opc == OPC_OP) ? ref_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        known = (opc == OPC_OP) || (opc == OPC_OP_IMM) || (opc == OPC_LUI);
        case (f3)
            3'd0: r = ((opc == OPC_OP) && w[30]) ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (w[30]) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        if (opc == OPC_LUI) begin
            r = {w[31:12], 12'd0};
        end
        exp_rd_mem[idx]   = w[11:7];
        exp_we_mem[idx]   = known && (w[11:7] != 5'd0);
        exp_data_mem[idx] = r;
        exp_chk_mem[idx]  = known;
        if (exp_we_mem[idx]) begin
            ref_regs[w[11:7]] = r;
        end
    endtask

    task automatic add_instr(input instr_t w);
        prog[num_instr] = w;
        predict_beat(num_instr);
        num_instr++;
    endtask

    // small register window keeps dependent pairs frequent
    task automatic add_random_instr();
        instr_t      raw;
        instr_t      bits;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  opc;
        logic        alt;
        raw  = $random(seed);
        bits = $random(seed);
        f3   = raw[6:4];
        alt  = raw[16] && ((f3 == 3'd0) || (f3 == 3'd5));
        imm  = bits[11:0];
        if (f3 == 3'd1) begin
            imm = {7'd0, bits[4:0]};
        end else if (f3 == 3'd5) begin
            imm = {1'b0, alt, 5'd0, bits[4:0]};
        end
        case (raw[18:17])
            2'd0: opc = 7'b0000011;
            2'd1: opc = 7'b0100011;
            2'd2: opc = 7'b1100011;
            default: opc = 7'b1101111;
        endcase
        if (raw[3:0] < 4'd7) begin
            add_instr(r_type_word(alt ? 7'h20 : 7'h00, {2'b00, raw[15:13]},
                                  {2'b00, raw[12:10]}, f3, {2'b00, raw[9:7]}));
        end else if (raw[3:0] < 4'd13) begin
            add_instr(i_type_word(imm, {2'b00, raw[12:10]}, f3, {2'b00, raw[9:7]}));
        end else if (raw[3:0] < 4'd15) begin
            add_instr(lui_word(bits[31:12], {2'b00, raw[9:7]}));
        end else begin
            add_instr({bits[31:7], opc});
        end
    endtask

    task automatic build_program();
        add_instr(lui_word(20'h80000, 5'd1));
        add_instr(i_type_word(12'hfff, 5'd0, 3'd0, 5'd2));
        // x2 comes from ex and x1 from wb
        add_instr(r_type_word(7'h20, 5'd2, 5'd1, 3'd0, 5'd3));
        add_instr(i_type_word(12'h41f, 5'd1, 3'd5, 5'd4));
        add_instr(r_type_word(7'h00, 5'd1, 5'd2, 3'd3, 5'd5));
        add_instr(r_type_word(7'h00, 5'd2, 5'd1, 3'd3, 5'd6));
        add_instr(r_type_word(7'h00, 5'd2, 5'd1, 3'd2, 5'd7));
        add_instr(r_type_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
        add_instr(r_type_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd8));
        add_instr(32'h0000_4483);
        add_instr(i_type_word(12'd5, 5'd8, 3'd0, 5'd9));
        add_instr(i_type_word(12'd7, 5'd9, 3'd0, 5'd9));
        add_instr(r_type_word(7'h00, 5'd9, 5'd9, 3'd0, 5'd10));
        add_instr(r_type_word(7'h00, 5'd6, 5'd1, 3'd5, 5'd11));
        add_instr(r_type_word(7'h20, 5'd6, 5'd1, 3'd5, 5'd12));
        add_instr(r_type_word(7'h20, 5'd1, 5'd0, 3'd0, 5'd13));
        for (int i = 0; i < NUM_RANDOM; i++) begin
            add_random_instr();
        end
    endtask

    // monitor, sender and receiver all act on the falling edge
    always @(negedge clk) begin
        if (run) begin
            if (res_valid_o) begin
                if (beats_in >= num_instr) begin
                    report_plain("a result beat arrived with no instruction outstanding");
                end
                exp_rd    = exp_rd_mem[beats_in];
                exp_we    = exp_we_mem[beats_in];
                exp_data  = exp_data_mem[beats_in];
                exp_chk   = exp_chk_mem[beats_in];
                beat_held = beats_in - credits_out;
                beats_in++;
            end
            if (credit_o) begin
                in_credits++;
                credit_pulses++;
            end
            instr_valid_i = 1'b0;
            if ((in_credits > 0) && (sent < num_instr)) begin
                instr_valid_i = 1'b1;
                instr_i       = prog[sent];
                sent_any      = 1'b1;
                sent++;
                in_credits--;
            end
            res_credit_i = 1'b0;
            if (rx_wait > 0) begin
                rx_wait--;
            end else if ((beats_in > credits_out) && !withhold) begin
                res_credit_i = 1'b1;
                credits_out++;
                rx_wait = $unsigned($random(seed)) % 4;
            end
        end
    end

    quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n_i)
        !sent_any |-> (!res_valid_o && !credit_o))
        else report_plain("result or credit output active before any instruction was sent");

    beat_rd_check: assert property (@(posedge clk) disable iff (!rst_n_i)
        res_valid_o |-> (res_rd_o == exp_rd))
        else report_value("res_rd_o", data_t'($sampled(res_rd_o)), data_t'(exp_rd));

    beat_we_check: assert property (@(posedge clk) disable iff (!rst_n_i)
        res_valid_o |-> (res_we_o == exp_we))
        else report_value("res_we_o", data_t'($sampled(res_we_o)), data_t'(exp_we));

    beat_data_check: assert property (@(posedge clk) disable iff (!rst_n_i)
        (res_valid_o && exp_chk) |-> (res_data_o == exp_data))
        else report_value("res_data_o", $sampled(res_data_o), exp_data);

    out_credit_check: assert property (@(posedge clk) disable iff (!rst_n_i)
        res_valid_o |-> (beat_held < OUT_CREDITS))
        else report_plain("a result beat was sent without a free result credit");

    in_credit_check: assert property (@(posedge clk) disable iff (!rst_n_i)
        in_credits <= QUEUE_DEPTH)
        else report_plain("credit_o returned more credits than instructions were sent");

    // watchdog scaled to the program length
    initial begin
        wait (run);
        #(20 * num_instr * CLK_PERIOD);
        report_plain("timeout, the design stopped producing result beats");
    end

    initial begin
        seed          = 32'h88dd_4382;
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        res_credit_i  = 1'b0;
        run           = 1'b0;
        withhold      = 1'b0;
        sent_any      = 1'b0;
        sent          = 0;
        in_credits    = QUEUE_DEPTH;
        credit_pulses = 0;
        beats_in      = 0;
        credits_out   = 0;
        rx_wait       = 0;
        beat_held     = 0;
        exp_rd        = '0;
        exp_we        = 1'b0;
        exp_data      = '0;
        exp_chk       = 1'b0;
        num_instr     = 0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        build_program();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;
        // a few idle cycles where the outputs must stay quiet
        repeat (5) @(posedge clk);
        run = 1'b1;
        // starve the design of result credits for a while
        while (sent < 80) @(posedge clk);
        withhold = 1'b1;
        repeat (40) @(posedge clk);
        assert (beats_in - credits_out == OUT_CREDITS)
            else report_plain("receiver held back credits but the design did not use them all");
        withhold = 1'b0;
        while (beats_in < num_instr) @(posedge clk);
        repeat (10) @(posedge clk);
        assert ((credit_pulses == sent) && (sent == num_instr))
            else report_plain("credit_o pulse count differs from the instructions accepted");
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
